//--- hdl/sb_pkg.sv
`default_nettype none

package sb_pkg;

    // ##############################
    // bus widths

    localparam int addr_w = 64;
    localparam int data_w = 512;
    localparam int strb_w = 64;    // one bit per byte lane

    // ##############################
    // queue layout in shared memory

    localparam logic [addr_w-1:0] head_offset   = 64'd0;      // producer owns this word
    localparam logic [addr_w-1:0] tail_offset   = 64'd64;     // consumer owns this word
    localparam logic [addr_w-1:0] packet_offset = 64'd128;    // slot 0
    localparam logic [addr_w-1:0] packet_size   = 64'd64;     // one bus word per slot

    // ##############################
    // axi channel payloads

    typedef struct packed {
        logic [15:0]       id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
    } axi_ar_t;

    typedef struct packed {
        logic [15:0]       id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [15:0]       id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [15:0] id;
        logic [1:0]  resp;
    } axi_b_t;

    // ##############################
    // queue config and stream packet

    typedef struct packed {
        logic [addr_w-1:0] base_addr;
        logic [31:0]       capacity;     // in slots
    } queue_cfg_t;

    typedef struct packed {
        logic [255:0] data;
        logic [31:0]  dest;
        logic         last;
    } sb_pkt_t;

    // one memory word, read either as an index or as a packet slot
    typedef struct packed {
        logic [479:0] pad;
        logic [31:0]  index;
    } mem_index_t;

    typedef struct packed {
        logic [191:0] pad_hi;
        logic [255:0] data;
        logic [30:0]  pad_lo;
        logic         last;
        logic [31:0]  dest;
    } mem_packet_t;

    typedef union packed {
        mem_index_t  idx;
        mem_packet_t pkt;
    } mem_word_u;

endpackage

`default_nettype wire

//--- hdl/axi_reader.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic [sb_pkg::addr_w-1:0] addr,
    output logic                      done,
    output sb_pkg::mem_word_u         data,
    output sb_pkg::axi_ar_t           ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  sb_pkg::axi_r_t            r,
    input  logic                      rvalid,
    output logic                      rready
);

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data,
        s_done
    } rd_state_t;

    rd_state_t                 state;
    logic [sb_pkg::addr_w-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (req) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    if (arready) begin
                        state <= s_data;
                    end
                end
                s_data: begin
                    if (rvalid) begin
                        state <= s_done;
                    end
                end
                default: state <= s_idle;    // s_done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && req) begin
            addr_q <= addr;
        end
        if (state == s_data && rvalid) begin
            data <= r.data;
        end
    end

    assign ar.id   = '0;
    assign ar.addr = addr_q;
    assign ar.len  = 8'd0;    // single beat
    assign ar.size = 3'd6;    // 64 bytes

    assign arvalid = (state == s_addr);
    assign rready  = 1'b1;
    assign done    = (state == s_done);

endmodule

`default_nettype wire

//--- hdl/axi_writer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_writer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic [sb_pkg::addr_w-1:0] addr,
    input  logic [sb_pkg::strb_w-1:0] strb,
    input  logic [sb_pkg::data_w-1:0] data,
    output logic                      done,
    output sb_pkg::axi_aw_t           aw,
    output logic                      awvalid,
    input  logic                      awready,
    output sb_pkg::axi_w_t            w,
    output logic                      wvalid,
    input  logic                      wready,
    input  sb_pkg::axi_b_t            b,
    input  logic                      bvalid,
    output logic                      bready
);

    typedef enum logic [1:0] {
        s_idle,
        s_send,
        s_resp,
        s_done
    } wr_state_t;

    wr_state_t                 state;
    logic                      aw_pend;
    logic                      w_pend;
    logic                      aw_left;
    logic                      w_left;
    logic [sb_pkg::addr_w-1:0] addr_q;
    logic [sb_pkg::strb_w-1:0] strb_q;
    logic [sb_pkg::data_w-1:0] data_q;

    // still waiting after this cycle
    assign aw_left = aw_pend && !awready;
    assign w_left  = w_pend && !wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (req) begin
                        state   <= s_send;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
                s_send: begin
                    aw_pend <= aw_left;
                    w_pend  <= w_left;
                    if (!aw_left && !w_left) begin
                        state <= s_resp;
                    end
                end
                s_resp: begin
                    if (bvalid && b.id == '0) begin    // only id 0 is ever issued
                        state <= s_done;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && req) begin
            addr_q <= addr;
            strb_q <= strb;
            data_q <= data;
        end
    end

    assign aw.id   = '0;
    assign aw.addr = addr_q;
    assign aw.len  = 8'd0;
    assign aw.size = 3'd6;    // 64 bytes
    assign w.data  = data_q;
    assign w.strb  = strb_q;
    assign w.last  = 1'b1;

    assign awvalid = aw_pend;
    assign wvalid  = w_pend;
    assign bready  = 1'b1;
    assign done    = (state == s_done);

endmodule

`default_nettype wire

//--- hdl/memory_fault.sv
`timescale 1ns/1ps
`default_nettype none

module memory_fault (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid_in,
    input  logic [sb_pkg::addr_w-1:0] addr,
    input  logic [sb_pkg::addr_w-1:0] base,
    input  logic [sb_pkg::addr_w-1:0] length,
    output logic                      valid_out,
    output logic                      fault,
    output logic [sb_pkg::addr_w-1:0] fault_addr
);

    logic [sb_pkg::addr_w-1:0] limit;
    logic                      legal;

    assign limit = base + length;    // first byte past the region
    assign legal = (addr >= base) && (addr < limit);

    // request only reaches the bus when it is in range
    assign valid_out = valid_in && legal;

    // ##############################
    // sticky fault record

    always_ff @(posedge clk) begin
        if (reset) begin
            fault      <= 1'b0;
            fault_addr <= '0;
        end else if (valid_in && !legal && !fault) begin
            fault      <= 1'b1;
            fault_addr <= addr;    // keep the first offender
        end
    end

endmodule

`default_nettype wire

//--- hdl/sb_rx_fpga.sv
`timescale 1ns/1ps
`default_nettype none

module sb_rx_fpga (
    input  logic               clk,
    input  logic               reset,
    input  logic               en,
    input  sb_pkg::queue_cfg_t cfg,

    output sb_pkg::sb_pkt_t    pkt,
    output logic               valid,
    input  logic               ready,

    output logic               status_idle,

    output sb_pkg::axi_ar_t    ar,
    output logic               arvalid,
    input  logic               arready,
    input  sb_pkg::axi_r_t     r,
    input  logic               rvalid,
    output logic               rready,

    output sb_pkg::axi_aw_t    aw,
    output logic               awvalid,
    input  logic               awready,
    output sb_pkg::axi_w_t     w,
    output logic               wvalid,
    input  logic               wready,
    input  sb_pkg::axi_b_t     b,
    input  logic               bvalid,
    output logic               bready
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_tail,
        st_rd_head,
        st_rd_pkt,
        st_wr_tail,
        st_fault
    } state_t;

    state_t                    state;
    state_t                    state_next;

    logic                      rd_req;
    logic                      rd_done;
    logic [sb_pkg::addr_w-1:0] rd_addr;
    sb_pkg::mem_word_u         rd_data;
    logic                      idx_req;
    logic                      pkt_req;
    logic                      pkt_req_ok;

    logic                      wr_req;
    logic                      wr_req_ok;
    logic                      wr_done;
    sb_pkg::mem_word_u         wr_word;

    logic                      wr_fault;
    logic                      rd_fault;
    logic                      fault;

    logic [31:0]               head;
    logic [31:0]               tail;
    logic [31:0]               head_next;
    logic [31:0]               tail_next;
    logic [31:0]               tail_incr;
    logic                      empty;

    logic [sb_pkg::addr_w-1:0] head_addr;
    logic [sb_pkg::addr_w-1:0] tail_addr;
    logic [sb_pkg::addr_w-1:0] pkt_addr;
    logic [sb_pkg::addr_w-1:0] region_len;

    // ##############################
    // queue FSM

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (en && !valid) begin    // hold off while a packet is still out
                    state_next = st_rd_tail;
                end
            end
            st_rd_tail: begin
                if (rd_done) begin
                    if (!en) begin
                        state_next = st_idle;
                    end else if (empty) begin
                        state_next = st_rd_head;
                    end else begin
                        state_next = st_rd_pkt;
                    end
                end
            end
            st_rd_head: begin
                if (rd_done) begin
                    if (!en) begin
                        state_next = st_idle;
                    end else if (!empty) begin
                        state_next = st_rd_pkt;
                    end    // still empty, poll again
                end
            end
            st_rd_pkt: begin
                if (rd_done) begin
                    state_next = st_wr_tail;    // tail write always follows
                end
            end
            st_wr_tail: begin
                if (wr_done) begin
                    state_next = st_idle;
                end
            end
            st_fault: state_next = st_fault;
            default:  state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else if (fault) begin
            state <= st_fault;
        end else begin
            state <= state_next;
        end
    end

    // ##############################
    // head and tail tracking

    assign head_next = (state == st_rd_head && rd_done) ? rd_data.idx.index : head;
    assign tail_next = (state == st_rd_tail && rd_done) ? rd_data.idx.index : tail;
    assign empty     = (head_next == tail_next);

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= 32'd0;
            tail <= 32'd0;
        end else begin
            head <= head_next;
            tail <= tail_next;
        end
    end

    assign tail_incr = (tail + 32'd1 == cfg.capacity) ? 32'd0 : tail + 32'd1;

    // addresses
    assign head_addr  = cfg.base_addr + sb_pkg::head_offset;
    assign tail_addr  = cfg.base_addr + sb_pkg::tail_offset;
    assign pkt_addr   = cfg.base_addr + sb_pkg::packet_offset + {32'd0, tail} * sb_pkg::packet_size;
    assign region_len = {32'd0, cfg.capacity} * sb_pkg::packet_size + sb_pkg::packet_offset;

    // ##############################
    // memory access

    assign idx_req = (state == st_rd_tail) || (state == st_rd_head);
    assign pkt_req = (state == st_rd_pkt);
    assign rd_req  = idx_req || pkt_req_ok;
    assign wr_req  = (state == st_wr_tail);
    assign fault   = wr_fault || rd_fault;

    always_comb begin
        case (state)
            st_rd_head: rd_addr = head_addr;
            st_rd_pkt:  rd_addr = pkt_addr;
            default:    rd_addr = tail_addr;
        endcase
    end

    always_comb begin
        wr_word           = '0;
        wr_word.idx.index = tail_incr;
    end

    memory_fault u_rd_check (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (pkt_req),
        .addr       (pkt_addr),
        .base       (cfg.base_addr),
        .length     (region_len),
        .valid_out  (pkt_req_ok),
        .fault      (rd_fault),
        .fault_addr ()
    );

    memory_fault u_wr_check (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (wr_req),
        .addr       (tail_addr),
        .base       (cfg.base_addr),
        .length     (region_len),
        .valid_out  (wr_req_ok),
        .fault      (wr_fault),
        .fault_addr ()
    );

    axi_reader u_reader (
        .clk     (clk),
        .reset   (reset),
        .req     (rd_req),
        .addr    (rd_addr),
        .done    (rd_done),
        .data    (rd_data),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    axi_writer u_writer (
        .clk     (clk),
        .reset   (reset),
        .req     (wr_req_ok),
        .addr    (tail_addr),
        .strb    (64'h0000_0000_0000_00ff),    // low 8 bytes only
        .data    (wr_word),
        .done    (wr_done),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // ##############################
    // stream output

    // valid is always low on entry to st_rd_pkt, so nothing is overwritten
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (state == st_rd_pkt && rd_done) begin
            valid <= 1'b1;
        end else if (valid && ready) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_rd_pkt && rd_done) begin
            pkt.data <= rd_data.pkt.data;
            pkt.dest <= rd_data.pkt.dest;
            pkt.last <= rd_data.pkt.last;
        end
    end

    assign status_idle = (state == st_idle);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;    // 4 ns period

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  logic            clk,
    input  logic            reset,
    input  sb_pkg::axi_ar_t ar,
    input  logic            arvalid,
    output logic            arready,
    output sb_pkg::axi_r_t  r,
    output logic            rvalid,
    input  logic            rready,
    input  sb_pkg::axi_aw_t aw,
    input  logic            awvalid,
    output logic            awready,
    input  sb_pkg::axi_w_t  w,
    input  logic            wvalid,
    output logic            wready,
    output sb_pkg::axi_b_t  b,
    output logic            bvalid,
    input  logic            bready
);

    logic [511:0] mem [64];    // 64 words of 64 bytes, addr[11:6] selects
    logic [511:0] r_data;
    logic [511:0] merged;
    logic [511:0] w_data;
    logic [63:0]  w_strb;
    logic [5:0]   rd_idx;
    logic [5:0]   aw_idx;
    logic         rd_pend;
    logic         aw_got;
    logic         w_got;
    integer       rd_wait;
    integer       seed;
    integer       ar_count;
    integer       wr_count;
    integer       i;
    integer       k;

    initial begin
        seed    = 32'hb2bc_e05e;
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        r_data  = '0;
        for (i = 0; i < 64; i = i + 1) begin
            mem[i] = {16{i * 32'h9e37_79b9 + 32'h1234_0000}};
        end
    end

    assign r.id   = '0;
    assign r.data = r_data;
    assign r.resp = 2'b00;
    assign r.last = 1'b1;
    assign b.id   = '0;
    assign b.resp = 2'b00;

    // backdoor access by byte address
    task automatic poke(input logic [63:0] addr, input sb_pkg::mem_word_u word);
        mem[addr[11:6]] = word;
    endtask

    function automatic sb_pkg::mem_word_u peek(input logic [63:0] addr);
        return mem[addr[11:6]];
    endfunction

    // ##############################
    // read side

    always @(posedge clk) begin
        if (reset) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rd_pend  <= 1'b0;
            rd_wait  <= 0;
            ar_count <= 0;
        end else begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                rd_pend  <= 1'b1;
                rd_idx   <= ar.addr[11:6];
                rd_wait  <= $random(seed) & 3;    // 0..3 cycles before R
                ar_count <= ar_count + 1;
            end else if (!rd_pend && !rvalid) begin
                arready <= ($random(seed) & 1) != 0;
            end
            if (rd_pend) begin
                if (rd_wait == 0) begin
                    rvalid  <= 1'b1;
                    r_data  <= mem[rd_idx];
                    rd_pend <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ##############################
    // write side

    always @(posedge clk) begin
        if (reset) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            wr_count <= 0;
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                aw_idx  <= aw.addr[11:6];
            end else if (!aw_got && !bvalid) begin
                awready <= ($random(seed) & 1) != 0;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_got  <= 1'b1;
                w_data <= w.data;
                w_strb <= w.strb;
            end else if (!w_got && !bvalid) begin
                wready <= ($random(seed) & 1) != 0;
            end
            if (aw_got && w_got) begin
                merged = mem[aw_idx];
                for (k = 0; k < 64; k = k + 1) begin
                    if (w_strb[k]) begin
                        merged[k*8 +: 8] = w_data[k*8 +: 8];    // byte lanes
                    end
                end
                mem[aw_idx] <= merged;
                bvalid      <= 1'b1;
                aw_got      <= 1'b0;
                w_got       <= 1'b0;
                wr_count    <= wr_count + 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/sb_rx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sb_rx_asserts (
    input logic            clk,
    input logic            reset,
    input sb_pkg::sb_pkt_t pkt,
    input logic            valid,
    input logic            ready,
    input sb_pkg::axi_ar_t ar,
    input logic            arvalid,
    input logic            arready,
    input sb_pkg::axi_aw_t aw,
    input logic            awvalid,
    input logic            awready,
    input sb_pkg::axi_w_t  w,
    input logic            wvalid,
    input logic            wready,
    input logic            rd_pkt_state,
    input logic            fault
);

    int fail_count = 0;    // failed assertions so far

    a_pkt_hold: assert property (@(posedge clk) disable iff (reset)
        valid && !ready |=> valid && $stable(pkt))
        else begin
            $error("stream packet changed or dropped before ready");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("AR dropped before arready");
            fail_count++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            $error("AW dropped before awready");
            fail_count++;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            $error("W dropped before wready");
            fail_count++;
        end

    // no fetch while a packet is still out
    a_no_fetch: assert property (@(posedge clk) disable iff (reset)
        valid && rd_pkt_state |-> !arvalid)
        else begin
            $error("packet read issued while valid is high");
            fail_count++;
        end

    a_fault_sticky: assert property (@(posedge clk) disable iff (reset)
        fault |=> fault)
        else begin
            $error("fault cleared without reset");
            fail_count++;
        end

endmodule

bind sb_rx_fpga sb_rx_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .pkt          (pkt),
    .valid        (valid),
    .ready        (ready),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .aw           (aw),
    .awvalid      (awvalid),
    .awready      (awready),
    .w            (w),
    .wvalid       (wvalid),
    .wready       (wready),
    .rd_pkt_state (state == st_rd_pkt),
    .fault        (fault)
);

`default_nettype wire

//--- testbench/sb_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sb_rx_tb;

    typedef struct packed {
        logic [31:0] cap;
        logic [31:0] tail;
        logic [31:0] count;        // packets the producer adds
        logic        rnd_ready;    // random back-pressure
        logic        late_head;    // start empty, advance head later
        logic        exp_fault;
    } entry_t;

    logic               clk;
    logic               reset;
    logic               en;
    logic               ready;
    logic               valid;
    logic               status_idle;
    sb_pkg::queue_cfg_t cfg;
    sb_pkg::sb_pkt_t    pkt;
    sb_pkg::axi_ar_t    ar;
    sb_pkg::axi_r_t     r;
    sb_pkg::axi_aw_t    aw;
    sb_pkg::axi_w_t     w;
    sb_pkg::axi_b_t     b;
    logic               arvalid;
    logic               arready;
    logic               rvalid;
    logic               rready;
    logic               awvalid;
    logic               awready;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    logic               bready;

    entry_t             tbl [6];
    sb_pkg::sb_pkt_t    exp_slot [16];
    integer             seed;
    integer             e;

    tb_clock u_clk (.clk(clk));

    sb_rx_fpga u_dut (
        .clk(clk), .reset(reset), .en(en), .cfg(cfg),
        .pkt(pkt), .valid(valid), .ready(ready), .status_idle(status_idle),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready)
    );

    axi_mem_model u_mem (
        .clk(clk), .reset(reset),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready)
    );

    // ##############################
    // checks

    task automatic stop_run;
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_run;
    endtask

    task automatic check_pkt(input string name, input sb_pkg::sb_pkt_t exp,
                             input sb_pkg::sb_pkt_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run;
        end
    endtask

    task automatic check_index(input string name, input logic [31:0] exp,
                               input sb_pkg::mem_word_u act);
        if (act.idx.index !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act.idx.index);
            stop_run;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run;
        end
    endtask

    // bound checker counts its failed assertions
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("an assertion in the bound checker failed");
            stop_run;
        end
    end

    // ##############################
    // stimulus helpers

    task automatic apply_reset;
        @(posedge clk);
        reset <= 1'b1;
        en    <= 1'b0;
        ready <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic set_index(input logic [63:0] addr, input logic [31:0] value);
        sb_pkg::mem_word_u word;
        word           = '0;
        word.idx.index = value;
        u_mem.poke(addr, word);
    endtask

    task automatic load_queue(input entry_t ent, input logic [63:0] base);
        sb_pkg::mem_word_u word;
        logic [31:0]       head;
        integer            draw;
        integer            s;
        head = ent.late_head ? ent.tail : (ent.tail + ent.count) % ent.cap;
        set_index(base + 64'd0, head);
        set_index(base + 64'd64, ent.tail);
        for (s = 0; s < ent.cap; s = s + 1) begin
            word.pkt.pad_hi = {6{$random(seed)}};
            word.pkt.data   = {8{$random(seed)}};
            draw            = $random(seed);
            word.pkt.pad_lo = draw[30:0];
            word.pkt.last   = draw[31];
            word.pkt.dest   = $random(seed);
            exp_slot[s].data = word.pkt.data;
            exp_slot[s].dest = word.pkt.dest;
            exp_slot[s].last = word.pkt.last;
            u_mem.poke(base + 64'd128 + s * 64, word);
        end
    endtask

    task automatic take_packet(input logic rnd, output sb_pkg::sb_pkt_t got);
        integer timer;
        integer draw;
        logic   taken;
        timer = 0;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            draw = $random(seed);
            ready <= !rnd || draw[0];
            @(negedge clk);
            if (valid && ready) begin
                got   = pkt;
                taken = 1'b1;
            end else if (timer > 500) begin
                timeout("a packet on the stream");
            end
            timer = timer + 1;
        end
        @(posedge clk);
        ready <= 1'b0;    // transfer completes on this edge
    endtask

    task automatic wait_writes(input integer target);
        integer timer;
        timer = 0;
        while (u_mem.wr_count < target) begin
            @(negedge clk);
            timer = timer + 1;
            if (timer > 500) begin
                timeout("the tail write-back");
            end
        end
    endtask

    task automatic expect_quiet(input integer cycles);
        integer n;
        for (n = 0; n < cycles; n = n + 1) begin
            @(negedge clk);
            check_bit("valid", 1'b0, valid);
        end
    endtask

    task automatic stop_and_idle;
        integer timer;
        integer ar_snap;
        timer = 0;
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        while (!status_idle) begin
            @(negedge clk);
            timer = timer + 1;
            if (timer > 500) begin
                timeout("status_idle after en dropped");
            end
        end
        ar_snap = u_mem.ar_count;
        repeat (20) @(negedge clk);
        check_bit("status_idle", 1'b1, status_idle);
        check_bit("ar_after_idle", 1'b0, u_mem.ar_count != ar_snap);
    endtask

    task automatic run_entry(input entry_t ent);
        sb_pkg::sb_pkt_t got;
        logic [31:0]     t;
        logic [63:0]     base;
        integer          i;
        base = 64'h1000;
        apply_reset;
        cfg.base_addr <= base;
        cfg.capacity  <= ent.cap;
        load_queue(ent, base);
        @(posedge clk);
        en <= 1'b1;
        if (ent.exp_fault) begin
            expect_quiet(100);
            check_bit("tail_write_seen", 1'b0, u_mem.wr_count != 0);
            check_bit("u_dut.fault", 1'b1, u_dut.fault);
            @(posedge clk);
            en <= 1'b0;
            expect_quiet(20);
            check_bit("status_idle", 1'b0, status_idle);
        end else begin
            if (ent.late_head) begin
                expect_quiet(60);    // head == tail, DUT keeps polling
                set_index(base + 64'd0, (ent.tail + ent.count) % ent.cap);
            end
            t = ent.tail;
            for (i = 0; i < ent.count; i = i + 1) begin
                take_packet(ent.rnd_ready, got);
                check_pkt("pkt", exp_slot[t], got);
                t = (t + 1) % ent.cap;
                wait_writes(i + 1);
                check_index("tail_word", t, u_mem.peek(base + 64'd64));
            end
            expect_quiet(40);
            stop_and_idle;
        end
    endtask

    // ##############################
    // main sequence

    initial begin
        seed  = 32'hb2bc_e05e;
        reset = 1'b1;
        en    = 1'b0;
        ready = 1'b0;
        cfg   = '0;

        //        cap    tail   count  rnd   late  fault
        tbl[0] = {32'd4, 32'd0, 32'd3, 1'b0, 1'b0, 1'b0};
        tbl[1] = {32'd4, 32'd2, 32'd3, 1'b0, 1'b0, 1'b0};    // wraps 3 -> 0
        tbl[2] = {32'd8, 32'd0, 32'd2, 1'b0, 1'b1, 1'b0};
        tbl[3] = {32'd6, 32'd3, 32'd5, 1'b1, 1'b0, 1'b0};
        tbl[4] = {32'd4, 32'd7, 32'd1, 1'b0, 1'b0, 1'b1};    // tail past capacity
        tbl[5] = {32'd2, 32'd1, 32'd1, 1'b1, 1'b0, 1'b0};    // wraps 1 -> 0

        for (e = 0; e < 6; e = e + 1) begin
            run_entry(tbl[e]);
        end

        @(negedge clk);
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("an assertion in the bound checker failed");
            stop_run;
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sb_rx.f
hdl/sb_pkg.sv
hdl/axi_reader.sv
hdl/axi_writer.sv
hdl/memory_fault.sv
hdl/sb_rx_fpga.sv
testbench/tb_clock.sv
testbench/axi_mem_model.sv
testbench/sb_rx_asserts.sv
testbench/sb_rx_tb.sv

//--- Bender.yml
package:
  name: sb_rx

sources:
  - files:
      - hdl/sb_pkg.sv
      - hdl/axi_reader.sv
      - hdl/axi_writer.sv
      - hdl/memory_fault.sv
      - hdl/sb_rx_fpga.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/axi_mem_model.sv
      - testbench/sb_rx_asserts.sv
      - testbench/sb_rx_tb.sv
